//--- logic/core_pkg.sv
package core_pkg;

  // ---------------------------------------------------------------------------
  // Widths and vector types
  // ---------------------------------------------------------------------------
  localparam int unsigned DefaultXlen = 64;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [3:0]  cause_t;

  // ---------------------------------------------------------------------------
  // Major opcodes
  // ---------------------------------------------------------------------------
  localparam logic [6:0] OpcodeOp    = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm = 7'b0010011;
  localparam logic [6:0] OpcodeLui   = 7'b0110111;

  // ---------------------------------------------------------------------------
  // ALU operations
  // ---------------------------------------------------------------------------
  localparam alu_op_t AluAdd  = 4'd0;
  localparam alu_op_t AluSub  = 4'd1;
  localparam alu_op_t AluAnd  = 4'd2;
  localparam alu_op_t AluOr   = 4'd3;
  localparam alu_op_t AluXor  = 4'd4;
  localparam alu_op_t AluSlt  = 4'd5;
  localparam alu_op_t AluSltu = 4'd6;
  localparam alu_op_t AluSll  = 4'd7;
  localparam alu_op_t AluSrl  = 4'd8;
  localparam alu_op_t AluSra  = 4'd9;
  // Passes operand b, which holds the U-immediate
  localparam alu_op_t AluLui  = 4'd10;

  // Exception causes
  localparam cause_t IllegalInstrCause = 4'd2;

endpackage

//--- logic/decode_stage.sv
module decode_stage #(
  parameter int unsigned Xlen = core_pkg::DefaultXlen
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_valid_i,
  input  core_pkg::instr_t    fetch_instr_i,
  input  logic [Xlen-1:0]     boot_addr_i,
  output logic                dec_valid_o,
  output logic [Xlen-1:0]     dec_pc_o,
  output core_pkg::alu_op_t   dec_op_o,
  output core_pkg::reg_addr_t dec_rs1_o,
  output core_pkg::reg_addr_t dec_rs2_o,
  output logic                dec_use_imm_o,
  output logic [Xlen-1:0]     dec_imm_o,
  output core_pkg::reg_addr_t dec_rd_o,
  output logic                dec_we_o,
  output logic                dec_illegal_o
);

  import core_pkg::*;

  logic [Xlen-1:0] pc_q;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  reg_addr_t       rd;
  logic            shamt_ok;
  alu_op_t         op;
  logic            use_imm;
  logic            illegal;
  logic [Xlen-1:0] imm_i;
  logic [Xlen-1:0] imm_u;

  assign opcode = fetch_instr_i[6:0];
  assign rd     = fetch_instr_i[11:7];
  assign funct3 = fetch_instr_i[14:12];
  assign funct7 = fetch_instr_i[31:25];

  // Bit 25 belongs to the shift amount only on RV64
  assign shamt_ok = (Xlen > 32) || !fetch_instr_i[25];

  // Sign-extended immediates
  assign imm_i = Xlen'($signed(fetch_instr_i[31:20]));
  assign imm_u = Xlen'($signed({fetch_instr_i[31:12], 12'b0}));

  // ---------------------------------------------------------------------------
  // Instruction classification
  // ---------------------------------------------------------------------------
  always_comb begin
    op      = AluAdd;
    use_imm = 1'b0;
    illegal = 1'b0;
    case (opcode)
      OpcodeOp: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = AluAdd;
          {7'b0100000, 3'b000}: op = AluSub;
          {7'b0000000, 3'b001}: op = AluSll;
          {7'b0000000, 3'b010}: op = AluSlt;
          {7'b0000000, 3'b011}: op = AluSltu;
          {7'b0000000, 3'b100}: op = AluXor;
          {7'b0000000, 3'b101}: op = AluSrl;
          {7'b0100000, 3'b101}: op = AluSra;
          {7'b0000000, 3'b110}: op = AluOr;
          {7'b0000000, 3'b111}: op = AluAnd;
          default:              illegal = 1'b1;
        endcase
      end
      OpcodeOpImm: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: op = AluAdd;
          3'b010: op = AluSlt;
          3'b011: op = AluSltu;
          3'b100: op = AluXor;
          3'b110: op = AluOr;
          3'b111: op = AluAnd;
          3'b001: begin
            op      = AluSll;
            illegal = (fetch_instr_i[31:26] != 6'b000000) || !shamt_ok;
          end
          default: begin
            // Bit 30 tells SRAI from SRLI for funct3 101
            op      = fetch_instr_i[30] ? AluSra : AluSrl;
            illegal = ({fetch_instr_i[31], fetch_instr_i[29:26]} != 5'b00000) || !shamt_ok;
          end
        endcase
      end
      OpcodeLui: begin
        op      = AluLui;
        use_imm = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  // ---------------------------------------------------------------------------
  // PC and decode register
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q          <= boot_addr_i;
      dec_valid_o   <= 1'b0;
      dec_we_o      <= 1'b0;
      dec_illegal_o <= 1'b0;
    end else begin
      dec_valid_o   <= fetch_valid_i;
      dec_we_o      <= fetch_valid_i && !illegal && (rd != '0);
      dec_illegal_o <= fetch_valid_i && illegal;
      if (fetch_valid_i) begin
        pc_q <= pc_q + Xlen'(4);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      dec_pc_o      <= pc_q;
      dec_op_o      <= op;
      dec_rs1_o     <= fetch_instr_i[19:15];
      dec_rs2_o     <= fetch_instr_i[24:20];
      dec_use_imm_o <= use_imm;
      dec_imm_o     <= (opcode == OpcodeLui) ? imm_u : imm_i;
      dec_rd_o      <= rd;
    end
  end

endmodule

//--- logic/register_file.sv
module register_file #(
  parameter int unsigned Xlen = core_pkg::DefaultXlen
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output logic [Xlen-1:0]     rdata_a_o,
  output logic [Xlen-1:0]     rdata_b_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  logic [Xlen-1:0]     wdata_i
);

  import core_pkg::*;

  // x0 has no storage
  logic [Xlen-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      for (int unsigned i = 1; i < 32; i++) begin
        if (waddr_i == reg_addr_t'(i)) begin
          regs_q[i] <= wdata_i;
        end
      end
    end
  end

  // Index 0 falls through to zero on both read ports
  always_comb begin
    rdata_a_o = '0;
    for (int unsigned i = 1; i < 32; i++) begin
      if (raddr_a_i == reg_addr_t'(i)) begin
        rdata_a_o = regs_q[i];
      end
    end
  end

  always_comb begin
    rdata_b_o = '0;
    for (int unsigned i = 1; i < 32; i++) begin
      if (raddr_b_i == reg_addr_t'(i)) begin
        rdata_b_o = regs_q[i];
      end
    end
  end

endmodule

//--- logic/execute_stage.sv
module execute_stage #(
  parameter int unsigned Xlen = core_pkg::DefaultXlen
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // From decode
  input  logic                dec_valid_i,
  input  logic [Xlen-1:0]     dec_pc_i,
  input  core_pkg::alu_op_t   dec_op_i,
  input  core_pkg::reg_addr_t dec_rs1_i,
  input  core_pkg::reg_addr_t dec_rs2_i,
  input  logic                dec_use_imm_i,
  input  logic [Xlen-1:0]     dec_imm_i,
  input  core_pkg::reg_addr_t dec_rd_i,
  input  logic                dec_we_i,
  input  logic                dec_illegal_i,
  // Register file read ports
  output core_pkg::reg_addr_t raddr_a_o,
  output core_pkg::reg_addr_t raddr_b_o,
  input  logic [Xlen-1:0]     rdata_a_i,
  input  logic [Xlen-1:0]     rdata_b_i,
  // To result stage
  output logic                ex_valid_o,
  output logic [Xlen-1:0]     ex_pc_o,
  output logic                ex_we_o,
  output core_pkg::reg_addr_t ex_rd_o,
  output logic [Xlen-1:0]     ex_result_o,
  output logic                ex_illegal_o
);

  import core_pkg::*;

  localparam int unsigned ShamtWidth = $clog2(Xlen);

  logic [Xlen-1:0]       rs1_value;
  logic [Xlen-1:0]       rs2_value;
  logic [Xlen-1:0]       operand_a;
  logic [Xlen-1:0]       operand_b;
  logic [ShamtWidth-1:0] shamt;
  logic [Xlen-1:0]       alu_result;

  assign raddr_a_o = dec_rs1_i;
  assign raddr_b_o = dec_rs2_i;

  // ---------------------------------------------------------------------------
  // Operand bypass
  // ---------------------------------------------------------------------------
  // The instruction ahead is not yet in the register file
  assign rs1_value = (ex_we_o && ex_rd_o == dec_rs1_i && dec_rs1_i != '0) ? ex_result_o
                                                                          : rdata_a_i;
  assign rs2_value = (ex_we_o && ex_rd_o == dec_rs2_i && dec_rs2_i != '0) ? ex_result_o
                                                                          : rdata_b_i;

  assign operand_a = rs1_value;
  assign operand_b = dec_use_imm_i ? dec_imm_i : rs2_value;
  assign shamt     = operand_b[ShamtWidth-1:0];

  // ---------------------------------------------------------------------------
  // ALU
  // ---------------------------------------------------------------------------
  always_comb begin
    case (dec_op_i)
      AluAdd:  alu_result = operand_a + operand_b;
      AluSub:  alu_result = operand_a - operand_b;
      AluAnd:  alu_result = operand_a & operand_b;
      AluOr:   alu_result = operand_a | operand_b;
      AluXor:  alu_result = operand_a ^ operand_b;
      AluSlt:  alu_result = Xlen'($signed(operand_a) < $signed(operand_b));
      AluSltu: alu_result = Xlen'(operand_a < operand_b);
      AluSll:  alu_result = operand_a << shamt;
      AluSrl:  alu_result = operand_a >> shamt;
      AluSra:  alu_result = $unsigned($signed(operand_a) >>> shamt);
      AluLui:  alu_result = operand_b;
      default: alu_result = '0;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Execute register
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_o   <= 1'b0;
      ex_we_o      <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else begin
      ex_valid_o   <= dec_valid_i;
      ex_we_o      <= dec_valid_i && dec_we_i;
      ex_illegal_o <= dec_valid_i && dec_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      ex_pc_o     <= dec_pc_i;
      ex_rd_o     <= dec_rd_i;
      // Illegal encodings carry no result
      ex_result_o <= dec_illegal_i ? '0 : alu_result;
    end
  end

endmodule

//--- logic/result_stage.sv
module result_stage #(
  parameter int unsigned Xlen = core_pkg::DefaultXlen
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // From execute
  input  logic                ex_valid_i,
  input  logic [Xlen-1:0]     ex_pc_i,
  input  logic                ex_we_i,
  input  core_pkg::reg_addr_t ex_rd_i,
  input  logic [Xlen-1:0]     ex_result_i,
  input  logic                ex_illegal_i,
  // Register write-back
  output logic                wb_we_o,
  output core_pkg::reg_addr_t wb_waddr_o,
  output logic [Xlen-1:0]     wb_wdata_o,
  // Commit port
  output logic                commit_valid_o,
  output logic [Xlen-1:0]     commit_pc_o,
  output logic                commit_we_o,
  output core_pkg::reg_addr_t commit_waddr_o,
  output logic [Xlen-1:0]     commit_wdata_o,
  output logic                commit_ex_valid_o,
  output core_pkg::cause_t    commit_ex_cause_o
);

  import core_pkg::*;

  logic commit_we;

  assign commit_we = ex_valid_i && ex_we_i && !ex_illegal_i;

  // Write lands at the same edge that loads the commit record
  assign wb_we_o    = commit_we;
  assign wb_waddr_o = ex_rd_i;
  assign wb_wdata_o = ex_result_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_o    <= 1'b0;
      commit_we_o       <= 1'b0;
      commit_ex_valid_o <= 1'b0;
    end else begin
      commit_valid_o    <= ex_valid_i;
      commit_we_o       <= commit_we;
      commit_ex_valid_o <= ex_valid_i && ex_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      commit_pc_o       <= ex_pc_i;
      commit_waddr_o    <= ex_rd_i;
      commit_wdata_o    <= ex_result_i;
      commit_ex_cause_o <= ex_illegal_i ? IllegalInstrCause : cause_t'(0);
    end
  end

endmodule

//--- logic/core_top.sv
module core_top #(
  parameter int unsigned Xlen = core_pkg::DefaultXlen
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [Xlen-1:0]     boot_addr_i,
  input  logic                fetch_valid_i,
  input  core_pkg::instr_t    fetch_instr_i,
  // Commit port
  output logic                commit_valid_o,
  output logic [Xlen-1:0]     commit_pc_o,
  output logic                commit_we_o,
  output core_pkg::reg_addr_t commit_waddr_o,
  output logic [Xlen-1:0]     commit_wdata_o,
  output logic                commit_ex_valid_o,
  output core_pkg::cause_t    commit_ex_cause_o
);

  import core_pkg::*;

  // Decode to execute
  logic            dec_valid;
  logic [Xlen-1:0] dec_pc;
  alu_op_t         dec_op;
  reg_addr_t       dec_rs1;
  reg_addr_t       dec_rs2;
  logic            dec_use_imm;
  logic [Xlen-1:0] dec_imm;
  reg_addr_t       dec_rd;
  logic            dec_we;
  logic            dec_illegal;
  // Register file read
  reg_addr_t       rf_raddr_a;
  reg_addr_t       rf_raddr_b;
  logic [Xlen-1:0] rf_rdata_a;
  logic [Xlen-1:0] rf_rdata_b;
  // Execute to result
  logic            ex_valid;
  logic [Xlen-1:0] ex_pc;
  logic            ex_we;
  reg_addr_t       ex_rd;
  logic [Xlen-1:0] ex_result;
  logic            ex_illegal;
  // Write-back
  logic            wb_we;
  reg_addr_t       wb_waddr;
  logic [Xlen-1:0] wb_wdata;

  decode_stage #(
    .Xlen ( Xlen )
  ) decode_stage_i (
    .clk_i,
    .rst_ni,
    .fetch_valid_i,
    .fetch_instr_i,
    .boot_addr_i,
    .dec_valid_o   ( dec_valid   ),
    .dec_pc_o      ( dec_pc      ),
    .dec_op_o      ( dec_op      ),
    .dec_rs1_o     ( dec_rs1     ),
    .dec_rs2_o     ( dec_rs2     ),
    .dec_use_imm_o ( dec_use_imm ),
    .dec_imm_o     ( dec_imm     ),
    .dec_rd_o      ( dec_rd      ),
    .dec_we_o      ( dec_we      ),
    .dec_illegal_o ( dec_illegal )
  );

  register_file #(
    .Xlen ( Xlen )
  ) register_file_i (
    .clk_i,
    .rst_ni,
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( wb_we      ),
    .waddr_i   ( wb_waddr   ),
    .wdata_i   ( wb_wdata   )
  );

  execute_stage #(
    .Xlen ( Xlen )
  ) execute_stage_i (
    .clk_i,
    .rst_ni,
    .dec_valid_i   ( dec_valid   ),
    .dec_pc_i      ( dec_pc      ),
    .dec_op_i      ( dec_op      ),
    .dec_rs1_i     ( dec_rs1     ),
    .dec_rs2_i     ( dec_rs2     ),
    .dec_use_imm_i ( dec_use_imm ),
    .dec_imm_i     ( dec_imm     ),
    .dec_rd_i      ( dec_rd      ),
    .dec_we_i      ( dec_we      ),
    .dec_illegal_i ( dec_illegal ),
    .raddr_a_o     ( rf_raddr_a  ),
    .raddr_b_o     ( rf_raddr_b  ),
    .rdata_a_i     ( rf_rdata_a  ),
    .rdata_b_i     ( rf_rdata_b  ),
    .ex_valid_o    ( ex_valid    ),
    .ex_pc_o       ( ex_pc       ),
    .ex_we_o       ( ex_we       ),
    .ex_rd_o       ( ex_rd       ),
    .ex_result_o   ( ex_result   ),
    .ex_illegal_o  ( ex_illegal  )
  );

  result_stage #(
    .Xlen ( Xlen )
  ) result_stage_i (
    .clk_i,
    .rst_ni,
    .ex_valid_i   ( ex_valid   ),
    .ex_pc_i      ( ex_pc      ),
    .ex_we_i      ( ex_we      ),
    .ex_rd_i      ( ex_rd      ),
    .ex_result_i  ( ex_result  ),
    .ex_illegal_i ( ex_illegal ),
    .wb_we_o      ( wb_we      ),
    .wb_waddr_o   ( wb_waddr   ),
    .wb_wdata_o   ( wb_wdata   ),
    .commit_valid_o,
    .commit_pc_o,
    .commit_we_o,
    .commit_waddr_o,
    .commit_wdata_o,
    .commit_ex_valid_o,
    .commit_ex_cause_o
  );

endmodule

//--- test/tb_core.sv
module tb_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Xlen      = 64;
  localparam int unsigned MaxLines  = 64;
  localparam realtime     Period    = 100ns;
  localparam int unsigned ResetCyc  = 3;
  localparam logic [63:0] BootAddr  = 64'h0000_0000_8000_0000;

  logic        clk_i;
  logic        rst_ni;
  logic [63:0] boot_addr_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_instr_i;

  logic        commit_valid_o;
  logic [63:0] commit_pc_o;
  logic        commit_we_o;
  logic [4:0]  commit_waddr_o;
  logic [63:0] commit_wdata_o;
  logic        commit_ex_valid_o;
  logic [3:0]  commit_ex_cause_o;

  // Golden table
  int          test_no   [MaxLines];
  int          idle_cyc  [MaxLines];
  logic [31:0] instr_mem [MaxLines];
  logic        exp_we    [MaxLines];
  int          exp_rd    [MaxLines];
  logic [63:0] exp_wdata [MaxLines];
  logic        exp_ex    [MaxLines];
  logic [3:0]  exp_cause [MaxLines];
  int          n_lines;
  int          total_idle;
  logic        loaded;

  int commit_idx;
  int error_count;
  int test_errors;
  int tests_passed;
  int tests_failed;

  core_top #(
    .Xlen ( Xlen )
  ) dut_i (
    .clk_i,
    .rst_ni,
    .boot_addr_i,
    .fetch_valid_i,
    .fetch_instr_i,
    .commit_valid_o,
    .commit_pc_o,
    .commit_we_o,
    .commit_waddr_o,
    .commit_wdata_o,
    .commit_ex_valid_o,
    .commit_ex_cause_o
  );

  always #(Period / 2) clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  task automatic load_golden();
    int    fd;
    int    code;
    string line;
    fd = $fopen("test/core_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/core_golden.txt");
      return;
    end
    while (!$feof(fd) && n_lines < MaxLines) begin
      code = $fgets(line, fd);
      if (code > 1 && line.substr(0, 0) != "#") begin
        code = $sscanf(line, "%d %d %h %h %d %h %h %h", test_no[n_lines],
                       idle_cyc[n_lines], instr_mem[n_lines], exp_we[n_lines],
                       exp_rd[n_lines], exp_wdata[n_lines], exp_ex[n_lines],
                       exp_cause[n_lines]);
        if (code == 8) begin
          total_idle += idle_cyc[n_lines];
          n_lines++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_field(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    assert (act_val === exp_val) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
      error_count++;
      test_errors++;
    end
  endtask

  function automatic logic last_of_test(input int idx);
    return (idx == n_lines - 1) || (test_no[idx + 1] != test_no[idx]);
  endfunction

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    boot_addr_i   = BootAddr;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    n_lines       = 0;
    total_idle    = 0;
    loaded        = 1'b0;
    commit_idx    = 0;
    error_count   = 0;
    test_errors   = 0;
    tests_passed  = 0;
    tests_failed  = 0;

    load_golden();
    assert (n_lines > 0) else begin
      $display("Golden file holds no stimulus lines");
      error_count++;
    end
    loaded = 1'b1;

    repeat (ResetCyc) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < n_lines; i++) begin
      for (int k = 0; k < idle_cyc[i]; k++) begin
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
      end
      @(negedge clk_i);
      fetch_valid_i = 1'b1;
      fetch_instr_i = instr_mem[i];
    end
    @(negedge clk_i);
    fetch_valid_i = 1'b0;

    wait (commit_idx == n_lines);
    // A few more cycles to catch stray commits
    repeat (3) @(negedge clk_i);

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // ---------------------------------------------------------------------------
  // Commit checker
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!commit_valid_o) begin
      // Also covers reset and the cycles before the first commit
      assert (!commit_we_o && !commit_ex_valid_o) else begin
        $display("Commit write or exception flag raised without a commit at %0t", $time);
        error_count++;
      end
    end else begin
      assert (commit_idx < n_lines) else begin
        $display("Unexpected extra commit at %0t", $time);
        error_count++;
      end
      if (commit_idx < n_lines) begin
        check_field("commit_pc_o", BootAddr + 64'(4 * commit_idx), commit_pc_o);
        check_field("commit_we_o", 64'(exp_we[commit_idx]), 64'(commit_we_o));
        check_field("commit_waddr_o", 64'(exp_rd[commit_idx]), 64'(commit_waddr_o));
        check_field("commit_wdata_o", exp_wdata[commit_idx], commit_wdata_o);
        check_field("commit_ex_valid_o", 64'(exp_ex[commit_idx]), 64'(commit_ex_valid_o));
        check_field("commit_ex_cause_o", 64'(exp_cause[commit_idx]),
                    64'(commit_ex_cause_o));
        if (last_of_test(commit_idx)) begin
          if (test_errors == 0) begin
            $display("Test %0d: ok", test_no[commit_idx]);
            tests_passed++;
          end else begin
            $display("Test %0d: %0d mismatches", test_no[commit_idx], test_errors);
            tests_failed++;
          end
          test_errors = 0;
        end
        commit_idx++;
      end
    end
  end

  // Watchdog sized from the golden table
  initial begin
    wait (loaded);
    #((n_lines + total_idle + ResetCyc + 10) * Period);
    $display("Timeout: %0d of %0d commits never arrived, first missing is line %0d of test %0d",
             n_lines - commit_idx, n_lines, commit_idx,
             (commit_idx < n_lines) ? test_no[commit_idx] : -1);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- test/core_golden.txt
# test idle instr we rd wdata ex cause
# Hex except test, idle and rd, which are decimal
1 2 00500093 1 1 0000000000000005 0 0
1 0 ffd00113 1 2 fffffffffffffffd 0 0
1 0 800001b7 1 3 ffffffff80000000 0 0
1 0 7ff00213 1 4 00000000000007ff 0 0
2 0 002082b3 1 5 0000000000000002 0 0
2 0 40208333 1 6 0000000000000008 0 0
2 0 0040f3b3 1 7 0000000000000005 0 0
2 0 00116433 1 8 fffffffffffffffd 0 0
2 0 001144b3 1 9 fffffffffffffff8 0 0
2 0 00112533 1 10 0000000000000001 0 0
2 0 001135b3 1 11 0000000000000000 0 0
2 0 00109633 1 12 00000000000000a0 0 0
2 0 0011d6b3 1 13 07fffffffc000000 0 0
2 0 4011d733 1 14 fffffffffc000000 0 0
3 0 0f017793 1 15 00000000000000f0 0 0
3 0 ff00e813 1 16 fffffffffffffff5 0 0
3 0 fff0c893 1 17 fffffffffffffffa 0 0
3 0 ffe12913 1 18 0000000000000001 0 0
3 0 fff0b993 1 19 0000000000000001 0 0
3 0 02809a13 1 20 0000050000000000 0 0
3 0 0101da93 1 21 0000ffffffff8000 0 0
3 0 40115b13 1 22 fffffffffffffffe 0 0
3 0 12345bb7 1 23 0000000012345000 0 0
3 0 80000c13 1 24 fffffffffffff800 0 0
4 0 00100c93 1 25 0000000000000001 0 0
4 0 002c8c93 1 25 0000000000000003 0 0
4 0 019c8d33 1 26 0000000000000006 0 0
4 0 419d0db3 1 27 0000000000000003 0 0
4 0 01ac8e33 1 28 0000000000000009 0 0
5 0 00000000 0 0 0000000000000000 1 2
5 0 021080b3 0 1 0000000000000000 1 2
5 0 00008e93 1 29 0000000000000005 0 0
5 0 07b00013 0 0 000000000000007b 0 0
5 0 00100f33 1 30 0000000000000005 0 0
6 3 00700f93 1 31 0000000000000007 0 0
6 5 001f8f93 1 31 0000000000000008 0 0
6 1 001fc0b3 1 1 000000000000000d 0 0

//--- project.f
logic/core_pkg.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_top.sv
test/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_core
FILELIST  ?= project.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
